// ==== cq_pkg.sv ====
//------------------------------------------------------------
// shared definitions for the completer request front end
// descriptor layout follows the 128-bit completer request
// descriptor at the low end of the first beat of a request
// aperture codes outside 7..38 mask the address to zero
//------------------------------------------------------------
`default_nettype none

package cq_pkg;

   //------------------------------------------------------------
   // widths
   //------------------------------------------------------------
   localparam int DESC_WIDTH        = 128;
   localparam int ADDR_WIDTH        = 64;
   localparam int DWORD_COUNT_WIDTH = 11;

   // descriptor dwords on a start beat, not part of payload
   localparam int DESC_DWORDS = 4;

   // request type codes
   localparam logic [3:0] REQ_TYPE_MEM_READ  = 4'd0;
   localparam logic [3:0] REQ_TYPE_MEM_WRITE = 4'd1;

   // valid range of bar aperture codes
   localparam logic [5:0] APERTURE_MIN = 6'd7;
   localparam logic [5:0] APERTURE_MAX = 6'd38;

   //------------------------------------------------------------
   // descriptor, msb first
   //------------------------------------------------------------
   typedef struct packed {
      logic [6:0]                   rsvd_hi;
      logic [5:0]                   bar_aperture;
      logic [2:0]                   bar_id;
      logic [7:0]                   target_function;
      logic [7:0]                   tag;
      logic [15:0]                  requester_id;
      logic                         rsvd_lo;
      logic [3:0]                   req_type;
      logic [DWORD_COUNT_WIDTH-1:0] dword_count;
      logic [ADDR_WIDTH-1:0]        address;
   } cq_desc_t;

   // low part of a beat
   // descriptor on a start beat, payload on any other beat
   typedef union packed {
      cq_desc_t              desc;
      logic [DESC_WIDTH-1:0] raw;
   } cq_beat_u;

   //------------------------------------------------------------
   // aperture code to address mask
   //------------------------------------------------------------
   // code n keeps the low n address bits
   function automatic logic [ADDR_WIDTH-1:0] aperture_mask(
      input logic [5:0] code
   );
      logic [ADDR_WIDTH-1:0] mask;
      mask = '0;
      if (code >= APERTURE_MIN && code <= APERTURE_MAX) begin
         mask = (ADDR_WIDTH'(1) << code) - ADDR_WIDTH'(1);
      end
      return mask;
   endfunction

endpackage

`default_nettype wire

// ==== cq_request_router.sv ====
//------------------------------------------------------------
// classifies completer request beats and steers ready
// reads only the low descriptor part of each beat
// a start of an unsupported type is consumed together with
// all its beats up to and including the last one
//------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module cq_request_router (
   input  wire                            clk,
   input  wire                            rstn,

   // incoming beat, descriptor part only
   input  wire [cq_pkg::DESC_WIDTH-1:0]   cq_data_i,
   input  wire                            cq_sof_i,
   input  wire                            cq_last_i,
   input  wire                            cq_valid_i,
   output logic                           cq_ready_o,

   // stage handshake
   input  wire                            rd_space_i,
   input  wire                            wr_space_i,
   output logic                           rd_push_o,
   output logic                           wr_push_o
);

   cq_pkg::cq_beat_u beat;

   logic is_read;
   logic is_wr_start;
   logic is_wr_cont;
   logic is_write;
   logic is_drop;
   logic start_drop;

   // discarding the rest of an unsupported request
   logic drop_q;

   //------------------------------------------------------------
   // beat classification
   //------------------------------------------------------------
   assign beat.raw = cq_data_i;

   assign is_read     = cq_sof_i && (beat.desc.req_type == cq_pkg::REQ_TYPE_MEM_READ);
   assign is_wr_start = cq_sof_i && (beat.desc.req_type == cq_pkg::REQ_TYPE_MEM_WRITE);
   assign is_wr_cont  = !cq_sof_i && !drop_q;
   assign is_write    = is_wr_start || is_wr_cont;

   // any other start type, or a beat inside a dropped request
   assign start_drop  = cq_sof_i && !is_read && !is_wr_start;
   assign is_drop     = start_drop || (!cq_sof_i && drop_q);

   // dropped beats never stall
   assign cq_ready_o = (is_read && rd_space_i) || (is_write && wr_space_i) || is_drop;

   assign rd_push_o = cq_valid_i && is_read && rd_space_i;
   assign wr_push_o = cq_valid_i && is_write && wr_space_i;

   //------------------------------------------------------------
   // drop state
   //------------------------------------------------------------
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         drop_q <= 1'b0;
      end else if (cq_valid_i && cq_ready_o) begin
         if (cq_sof_i) begin
            // single-beat drops leave nothing to discard
            drop_q <= start_drop && !cq_last_i;
         end else if (cq_last_i) begin
            drop_q <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== cq_read_capture.sv ====
//------------------------------------------------------------
// one register stage for memory read requests
// push_i must only be raised while space_o is high
// output is held until rd_ready_i is seen high
//------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module cq_read_capture (
   input  wire                                   clk,
   input  wire                                   rstn,

   // from router
   input  wire                                   push_i,
   input  wire cq_pkg::cq_desc_t                 desc_i,
   output logic                                  space_o,

   // read request output
   output logic                                  rd_valid_o,
   output logic [cq_pkg::ADDR_WIDTH-1:0]         rd_addr_o,
   output logic [cq_pkg::DWORD_COUNT_WIDTH-1:0]  rd_dwords_o,
   output logic [7:0]                            rd_tag_o,
   output logic [15:0]                           rd_req_id_o,
   input  wire                                   rd_ready_i
);

   logic [cq_pkg::ADDR_WIDTH-1:0] addr_masked;

   // address limited to the bar aperture
   assign addr_masked = desc_i.address & cq_pkg::aperture_mask(desc_i.bar_aperture);

   // empty, or emptied this cycle
   assign space_o = !rd_valid_o || rd_ready_i;

   //------------------------------------------------------------
   // valid flag
   //------------------------------------------------------------
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         rd_valid_o <= 1'b0;
      end else if (push_i) begin
         rd_valid_o <= 1'b1;
      end else if (rd_ready_i) begin
         rd_valid_o <= 1'b0;
      end
   end

   //------------------------------------------------------------
   // request fields
   //------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (push_i) begin
         rd_addr_o   <= addr_masked;
         rd_dwords_o <= desc_i.dword_count;
         rd_tag_o    <= desc_i.tag;
         rd_req_id_o <= desc_i.requester_id;
      end
   end

endmodule

`default_nettype wire

// ==== cq_write_stage.sv ====
//------------------------------------------------------------
// one register stage for memory write beats
// push_i must only be raised while space_o is high
// dword count excludes the 4 descriptor dwords on sof
// address is latched on sof and reused for later beats
// keep is assumed contiguous from dword 0
//------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module cq_write_stage #(
   parameter int BUS_WIDTH = 256
) (
   input  wire                            clk,
   input  wire                            rstn,

   // from router and input stream
   input  wire                            push_i,
   input  wire [BUS_WIDTH-1:0]            data_i,
   input  wire [BUS_WIDTH/32-1:0]         keep_i,
   input  wire                            sof_i,
   input  wire                            last_i,
   output logic                           space_o,

   // write beat output
   output logic                           wr_valid_o,
   output logic [BUS_WIDTH-1:0]           wr_data_o,
   output logic [BUS_WIDTH/32-1:0]        wr_keep_o,
   output logic [3:0]                     wr_dwords_o,
   output logic [cq_pkg::ADDR_WIDTH-1:0]  wr_addr_o,
   output logic                           wr_sof_o,
   output logic                           wr_eof_o,
   input  wire                            wr_ready_i
);

   localparam int KEEP_WIDTH = BUS_WIDTH / 32;

   cq_pkg::cq_beat_u beat;

   logic [3:0]                    keep_count;
   logic [3:0]                    beat_dwords;
   logic [cq_pkg::ADDR_WIDTH-1:0] addr_masked;

   //------------------------------------------------------------
   // beat decode
   //------------------------------------------------------------
   assign beat.raw = data_i[cq_pkg::DESC_WIDTH-1:0];

   // only meaningful on a start beat
   assign addr_masked = beat.desc.address & cq_pkg::aperture_mask(beat.desc.bar_aperture);

   // popcount of keep
   always_comb begin
      keep_count = '0;
      for (int i = 0; i < KEEP_WIDTH; i++) begin
         keep_count = keep_count + 4'(keep_i[i]);
      end
   end

   assign beat_dwords = sof_i ? keep_count - 4'(cq_pkg::DESC_DWORDS) : keep_count;

   assign space_o = !wr_valid_o || wr_ready_i;

   //------------------------------------------------------------
   // control flags
   //------------------------------------------------------------
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         wr_valid_o <= 1'b0;
         wr_sof_o   <= 1'b0;
         wr_eof_o   <= 1'b0;
      end else if (push_i) begin
         wr_valid_o <= 1'b1;
         wr_sof_o   <= sof_i;
         wr_eof_o   <= last_i;
      end else if (wr_ready_i) begin
         wr_valid_o <= 1'b0;
      end
   end

   //------------------------------------------------------------
   // payload
   //------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (push_i) begin
         wr_data_o   <= data_i;
         wr_keep_o   <= keep_i;
         wr_dwords_o <= beat_dwords;
         // held across the continuation beats
         if (sof_i) begin
            wr_addr_o <= addr_masked;
         end
      end
   end

endmodule

`default_nettype wire

// ==== cq_completer_top.sv ====
//------------------------------------------------------------
// completer request receive front end
// BUS_WIDTH is 256 or 128, keep has one bit per dword
// memory reads and memory writes are forwarded, every other
// request type is consumed and dropped
// both outputs have a fixed latency of one cycle
//------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module cq_completer_top #(
   parameter int BUS_WIDTH = 256
) (
   input  wire                            clk,
   input  wire                            rstn,

   // completer request stream
   input  wire [BUS_WIDTH-1:0]            cq_data_i,
   input  wire [BUS_WIDTH/32-1:0]         cq_keep_i,
   input  wire                            cq_sof_i,
   input  wire                            cq_last_i,
   input  wire                            cq_valid_i,
   output logic                           cq_ready_o,

   // read requests
   output logic                                  rd_valid_o,
   output logic [cq_pkg::ADDR_WIDTH-1:0]         rd_addr_o,
   output logic [cq_pkg::DWORD_COUNT_WIDTH-1:0]  rd_dwords_o,
   output logic [7:0]                            rd_tag_o,
   output logic [15:0]                           rd_req_id_o,
   input  wire                                   rd_ready_i,

   // write beats
   output logic                           wr_valid_o,
   output logic [BUS_WIDTH-1:0]           wr_data_o,
   output logic [BUS_WIDTH/32-1:0]        wr_keep_o,
   output logic [3:0]                     wr_dwords_o,
   output logic [cq_pkg::ADDR_WIDTH-1:0]  wr_addr_o,
   output logic                           wr_sof_o,
   output logic                           wr_eof_o,
   input  wire                            wr_ready_i
);

   logic             rd_push;
   logic             wr_push;
   logic             rd_space;
   logic             wr_space;
   cq_pkg::cq_desc_t cq_desc;

   assign cq_desc = cq_pkg::cq_desc_t'(cq_data_i[cq_pkg::DESC_WIDTH-1:0]);

   //------------------------------------------------------------
   // control
   //------------------------------------------------------------
   cq_request_router u_router (
      .clk        (clk),
      .rstn       (rstn),
      .cq_data_i  (cq_data_i[cq_pkg::DESC_WIDTH-1:0]),
      .cq_sof_i   (cq_sof_i),
      .cq_last_i  (cq_last_i),
      .cq_valid_i (cq_valid_i),
      .cq_ready_o (cq_ready_o),
      .rd_space_i (rd_space),
      .wr_space_i (wr_space),
      .rd_push_o  (rd_push),
      .wr_push_o  (wr_push)
   );

   //------------------------------------------------------------
   // read and write paths
   //------------------------------------------------------------
   cq_read_capture u_read (
      .clk         (clk),
      .rstn        (rstn),
      .push_i      (rd_push),
      .desc_i      (cq_desc),
      .space_o     (rd_space),
      .rd_valid_o  (rd_valid_o),
      .rd_addr_o   (rd_addr_o),
      .rd_dwords_o (rd_dwords_o),
      .rd_tag_o    (rd_tag_o),
      .rd_req_id_o (rd_req_id_o),
      .rd_ready_i  (rd_ready_i)
   );

   cq_write_stage #(
      .BUS_WIDTH (BUS_WIDTH)
   ) u_write (
      .clk         (clk),
      .rstn        (rstn),
      .push_i      (wr_push),
      .data_i      (cq_data_i),
      .keep_i      (cq_keep_i),
      .sof_i       (cq_sof_i),
      .last_i      (cq_last_i),
      .space_o     (wr_space),
      .wr_valid_o  (wr_valid_o),
      .wr_data_o   (wr_data_o),
      .wr_keep_o   (wr_keep_o),
      .wr_dwords_o (wr_dwords_o),
      .wr_addr_o   (wr_addr_o),
      .wr_sof_o    (wr_sof_o),
      .wr_eof_o    (wr_eof_o),
      .wr_ready_i  (wr_ready_i)
   );

endmodule

`default_nettype wire

// ==== cq_completer_properties.sv ====
//------------------------------------------------------------
// concurrent checks bound to cq_completer_top
// sees only the ports of the top level
// drop state is tracked here from the input handshake
//------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module cq_completer_properties #(
   parameter int BUS_WIDTH = 256
) (
   input wire                                                   clk,
   input wire                                                   rstn,
   input wire [cq_pkg::DESC_WIDTH-1:0]                          cq_desc_i,
   input wire                                                   cq_sof_i,
   input wire                                                   cq_last_i,
   input wire                                                   cq_valid_i,
   input wire                                                   cq_ready_i,
   input wire                                                   rd_valid_i,
   input wire                                                   rd_ready_i,
   input wire [cq_pkg::ADDR_WIDTH+cq_pkg::DWORD_COUNT_WIDTH+23:0] rd_bus_i,
   input wire                                                   wr_valid_i,
   input wire                                                   wr_ready_i,
   input wire [BUS_WIDTH+BUS_WIDTH/32+cq_pkg::ADDR_WIDTH+5:0]   wr_bus_i
);

   cq_pkg::cq_desc_t desc;
   logic             other_start;
   logic             dropping;

   assign desc = cq_pkg::cq_desc_t'(cq_desc_i);
   assign other_start = cq_sof_i && desc.req_type != cq_pkg::REQ_TYPE_MEM_READ
                        && desc.req_type != cq_pkg::REQ_TYPE_MEM_WRITE;

   // inside a multi-beat request of an unsupported type
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         dropping <= 1'b0;
      end else if (cq_valid_i && cq_ready_i) begin
         if (cq_sof_i) begin
            dropping <= other_start && !cq_last_i;
         end else if (cq_last_i) begin
            dropping <= 1'b0;
         end
      end
   end

   rd_hold: assert property (@(posedge clk) disable iff (!rstn)
      rd_valid_i && !rd_ready_i |=> rd_valid_i && $stable(rd_bus_i))
      else $error("read output changed before its handshake");

   wr_hold: assert property (@(posedge clk) disable iff (!rstn)
      wr_valid_i && !wr_ready_i |=> wr_valid_i && $stable(wr_bus_i))
      else $error("write output changed before its handshake");

   reset_idle: assert property (@(posedge clk) !rstn |-> !rd_valid_i && !wr_valid_i)
      else $error("output valid high during reset");

   drop_ready: assert property (@(posedge clk) disable iff (!rstn)
      dropping && !cq_sof_i |-> cq_ready_i)
      else $error("input stalled while a request is being dropped");

endmodule

bind cq_completer_top cq_completer_properties #(
   .BUS_WIDTH (BUS_WIDTH)
) u_props (
   .clk        (clk),
   .rstn       (rstn),
   .cq_desc_i  (cq_data_i[cq_pkg::DESC_WIDTH-1:0]),
   .cq_sof_i   (cq_sof_i),
   .cq_last_i  (cq_last_i),
   .cq_valid_i (cq_valid_i),
   .cq_ready_i (cq_ready_o),
   .rd_valid_i (rd_valid_o),
   .rd_ready_i (rd_ready_i),
   .rd_bus_i   ({rd_addr_o, rd_dwords_o, rd_tag_o, rd_req_id_o}),
   .wr_valid_i (wr_valid_o),
   .wr_ready_i (wr_ready_i),
   .wr_bus_i   ({wr_data_o, wr_keep_o, wr_dwords_o, wr_addr_o, wr_sof_o, wr_eof_o})
);

`default_nettype wire

// ==== tb_cq_completer.sv ====
//------------------------------------------------------------
// testbench for the completer request front end
// runs with BUS_WIDTH 256 and beats taken from a table
// outputs are checked against queues of expected values
// built from the routing rules, one entry per handshake
//------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_cq_completer;

   localparam int BUS_WIDTH = 256;
   localparam int KEEP_W    = BUS_WIDTH / 32;
   localparam int TIMEOUT   = 200;

   typedef struct {
      logic                                 sof;
      logic                                 last;
      logic [KEEP_W-1:0]                    keep;
      logic [3:0]                           rtype;
      logic [cq_pkg::ADDR_WIDTH-1:0]        addr;
      logic [5:0]                           aperture;
      logic [cq_pkg::DWORD_COUNT_WIDTH-1:0] dwords;
      logic [7:0]                           tag;
      logic [15:0]                          req_id;
      logic [31:0]                          pay_seed;
      logic [7:0]                           rd_pat;
      logic [7:0]                           wr_pat;
   } beat_row_t;

   typedef struct {
      logic [BUS_WIDTH-1:0]          data;
      logic [KEEP_W-1:0]             keep;
      logic [3:0]                    dwords;
      logic [cq_pkg::ADDR_WIDTH-1:0] addr;
      logic                          sof;
      logic                          eof;
   } wr_exp_t;

   logic                                 clk;
   logic                                 rstn;
   logic [BUS_WIDTH-1:0]                 cq_data_i;
   logic [KEEP_W-1:0]                    cq_keep_i;
   logic                                 cq_sof_i;
   logic                                 cq_last_i;
   logic                                 cq_valid_i;
   logic                                 cq_ready_o;
   logic                                 rd_valid_o;
   logic [cq_pkg::ADDR_WIDTH-1:0]        rd_addr_o;
   logic [cq_pkg::DWORD_COUNT_WIDTH-1:0] rd_dwords_o;
   logic [7:0]                           rd_tag_o;
   logic [15:0]                          rd_req_id_o;
   logic                                 rd_ready_i;
   logic                                 wr_valid_o;
   logic [BUS_WIDTH-1:0]                 wr_data_o;
   logic [KEEP_W-1:0]                    wr_keep_o;
   logic [3:0]                           wr_dwords_o;
   logic [cq_pkg::ADDR_WIDTH-1:0]        wr_addr_o;
   logic                                 wr_sof_o;
   logic                                 wr_eof_o;
   logic                                 wr_ready_i;

   beat_row_t                     rows[$];
   cq_pkg::cq_desc_t              exp_rd[$];
   wr_exp_t                       exp_wr[$];
   logic [7:0]                    rd_pat;
   logic [7:0]                    wr_pat;
   logic [2:0]                    phase;
   logic                          model_drop;
   logic [cq_pkg::ADDR_WIDTH-1:0] model_wr_addr;
   logic                          timed_out;
   int                            seed;
   int                            mismatch_count;
   int                            other_count;

   cq_completer_top #(
      .BUS_WIDTH (BUS_WIDTH)
   ) uut (.*);

   always #5 clk = ~clk;

   // consumer ready follows the stall pattern of the current row
   always @(posedge clk) begin
      #1;
      rd_ready_i = rd_pat[phase];
      wr_ready_i = wr_pat[phase];
      phase = phase + 3'd1;
   end

   //------------------------------------------------------------
   // reference rules and compare tasks
   //------------------------------------------------------------
   // codes 7..38 open the low code bits of the address
   function automatic logic [cq_pkg::ADDR_WIDTH-1:0] bar_mask(input logic [5:0] code);
      logic [cq_pkg::ADDR_WIDTH-1:0] m;
      m = '0;
      if (code >= 6'd7 && code <= 6'd38) begin
         for (int b = 0; b < int'(code); b++) begin
            m[b] = 1'b1;
         end
      end
      return m;
   endfunction

   task automatic log_mismatch(input string name, input logic [BUS_WIDTH-1:0] got,
                               input logic [BUS_WIDTH-1:0] want);
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, want);
      mismatch_count++;
   endtask

   task automatic check_read(input cq_pkg::cq_desc_t want);
      if (rd_addr_o !== want.address)
         log_mismatch("rd_addr_o", BUS_WIDTH'(rd_addr_o), BUS_WIDTH'(want.address));
      if (rd_dwords_o !== want.dword_count)
         log_mismatch("rd_dwords_o", BUS_WIDTH'(rd_dwords_o), BUS_WIDTH'(want.dword_count));
      if (rd_tag_o !== want.tag)
         log_mismatch("rd_tag_o", BUS_WIDTH'(rd_tag_o), BUS_WIDTH'(want.tag));
      if (rd_req_id_o !== want.requester_id)
         log_mismatch("rd_req_id_o", BUS_WIDTH'(rd_req_id_o), BUS_WIDTH'(want.requester_id));
   endtask

   task automatic check_write(input wr_exp_t want);
      if (wr_data_o !== want.data)
         log_mismatch("wr_data_o", wr_data_o, want.data);
      if (wr_keep_o !== want.keep)
         log_mismatch("wr_keep_o", BUS_WIDTH'(wr_keep_o), BUS_WIDTH'(want.keep));
      if (wr_dwords_o !== want.dwords)
         log_mismatch("wr_dwords_o", BUS_WIDTH'(wr_dwords_o), BUS_WIDTH'(want.dwords));
      if (wr_addr_o !== want.addr)
         log_mismatch("wr_addr_o", BUS_WIDTH'(wr_addr_o), BUS_WIDTH'(want.addr));
      if (wr_sof_o !== want.sof)
         log_mismatch("wr_sof_o", BUS_WIDTH'(wr_sof_o), BUS_WIDTH'(want.sof));
      if (wr_eof_o !== want.eof)
         log_mismatch("wr_eof_o", BUS_WIDTH'(wr_eof_o), BUS_WIDTH'(want.eof));
   endtask

   // output handshakes complete on the next rising edge
   always @(negedge clk) begin
      if (rstn && rd_valid_o && rd_ready_i) begin
         if (exp_rd.size() == 0) begin
            $display("error at %0t: read request appeared with none expected", $time);
            other_count++;
         end else begin
            check_read(exp_rd.pop_front());
         end
      end
      if (rstn && wr_valid_o && wr_ready_i) begin
         if (exp_wr.size() == 0) begin
            $display("error at %0t: write beat appeared with none expected", $time);
            other_count++;
         end else begin
            check_write(exp_wr.pop_front());
         end
      end
   end

   //------------------------------------------------------------
   // stimulus
   //------------------------------------------------------------
   task automatic add_row(input int sof, input int last, input int keep, input int rtype,
                          input logic [cq_pkg::ADDR_WIDTH-1:0] addr, input int ap,
                          input int dw, input int tag, input int rid, input int pay,
                          input int rdp, input int wrp);
      beat_row_t r;
      r.sof      = (sof != 0);
      r.last     = (last != 0);
      r.keep     = keep[KEEP_W-1:0];
      r.rtype    = rtype[3:0];
      r.addr     = addr;
      r.aperture = ap[5:0];
      r.dwords   = dw[cq_pkg::DWORD_COUNT_WIDTH-1:0];
      r.tag      = tag[7:0];
      r.req_id   = rid[15:0];
      r.pay_seed = pay;
      r.rd_pat   = rdp[7:0];
      r.wr_pat   = wrp[7:0];
      rows.push_back(r);
   endtask

   task automatic send_beat(input beat_row_t r);
      logic [BUS_WIDTH-1:0] data;
      cq_pkg::cq_desc_t     desc;
      cq_pkg::cq_desc_t     rexp;
      wr_exp_t              wexp;
      logic                 is_read;
      logic                 is_write;
      int                   wait_cycles;
      for (int w = 0; w < KEEP_W; w++) begin
         data[w*32 +: 32] = $random(seed) ^ r.pay_seed;
      end
      desc = '0;
      desc.address      = r.addr;
      desc.dword_count  = r.dwords;
      desc.req_type     = r.rtype;
      desc.requester_id = r.req_id;
      desc.tag          = r.tag;
      desc.bar_aperture = r.aperture;
      if (r.sof)
         data[cq_pkg::DESC_WIDTH-1:0] = desc;
      rd_pat     = r.rd_pat;
      wr_pat     = r.wr_pat;
      cq_data_i  = data;
      cq_keep_i  = r.keep;
      cq_sof_i   = r.sof;
      cq_last_i  = r.last;
      cq_valid_i = 1'b1;
      wait_cycles = 0;
      @(negedge clk);
      while (!cq_ready_o && wait_cycles < TIMEOUT) begin
         @(negedge clk);
         wait_cycles++;
      end
      if (!cq_ready_o) begin
         $display("timeout at %0t: input beat not accepted in %0d cycles", $time, TIMEOUT);
         other_count++;
         timed_out = 1'b1;
      end else begin
         is_read  = 1'b0;
         is_write = 1'b0;
         if (r.sof) begin
            model_drop = 1'b0;
            if (r.rtype == cq_pkg::REQ_TYPE_MEM_READ) begin
               rexp = desc;
               rexp.address = r.addr & bar_mask(r.aperture);
               exp_rd.push_back(rexp);
               is_read = 1'b1;
            end else if (r.rtype == cq_pkg::REQ_TYPE_MEM_WRITE) begin
               model_wr_addr = r.addr & bar_mask(r.aperture);
               is_write = 1'b1;
            end else begin
               model_drop = !r.last;
            end
         end else if (model_drop) begin
            model_drop = !r.last;
         end else begin
            is_write = 1'b1;
         end
         if (is_write) begin
            wexp.data   = data;
            wexp.keep   = r.keep;
            wexp.dwords = 4'($countones(r.keep) - (r.sof ? cq_pkg::DESC_DWORDS : 0));
            wexp.addr   = model_wr_addr;
            wexp.sof    = r.sof;
            wexp.eof    = r.last;
            exp_wr.push_back(wexp);
         end
         @(posedge clk);
         #1;
         // accepted beat sits at its stage output one cycle later
         if (is_read) begin
            if (rd_valid_o !== 1'b1) begin
               $display("error at %0t: read request not presented one cycle late", $time);
               other_count++;
            end else begin
               check_read(rexp);
            end
         end
         if (is_write) begin
            if (wr_valid_o !== 1'b1) begin
               $display("error at %0t: write beat not presented one cycle late", $time);
               other_count++;
            end else begin
               check_write(wexp);
            end
         end
      end
   endtask

   task automatic drain_outputs();
      int wait_cycles;
      rd_pat = 8'hFF;
      wr_pat = 8'hFF;
      wait_cycles = 0;
      while ((exp_rd.size() != 0 || exp_wr.size() != 0) && wait_cycles < TIMEOUT) begin
         @(negedge clk);
         wait_cycles++;
      end
      if (exp_rd.size() != 0 || exp_wr.size() != 0) begin
         $display("timeout at %0t: %0d reads and %0d write beats never came out",
                  $time, exp_rd.size(), exp_wr.size());
         other_count++;
         timed_out = 1'b1;
      end
   endtask

   initial begin
      clk = 1'b0;
      rstn = 1'b0;
      cq_data_i = '0;
      cq_keep_i = '0;
      cq_sof_i = 1'b0;
      cq_last_i = 1'b0;
      cq_valid_i = 1'b0;
      rd_ready_i = 1'b1;
      wr_ready_i = 1'b1;
      rd_pat = 8'hFF;
      wr_pat = 8'hFF;
      phase = 3'd0;
      model_drop = 1'b0;
      model_wr_addr = '0;
      timed_out = 1'b0;
      seed = 49;
      mismatch_count = 0;
      other_count = 0;
      // sof last keep type addr aperture dwords tag req_id pay rd_pat wr_pat
      add_row(1, 1, 'h0F, 0, 64'h0000_0012_3456_789C, 20, 16, 'h11, 'h0100, 1, 'hFF, 'hFF);
      // three-beat write
      add_row(1, 0, 'hFF, 1, 64'hDEAD_BEEF_0000_1A40, 16, 20, 'h00, 'h0200, 2, 'hFF, 'hFF);
      add_row(0, 0, 'hFF, 0, 64'h0, 0, 0, 0, 0, 3, 'hFF, 'hFF);
      add_row(0, 1, 'h0F, 0, 64'h0, 0, 0, 0, 0, 4, 'hFF, 'hFF);
      // unsupported type over three beats, then a read and a write
      add_row(1, 0, 'hFF, 2, 64'h0000_0000_0BAD_0000, 12, 12, 'h21, 'h0300, 5, 'hFF, 'hFF);
      add_row(0, 0, 'hFF, 0, 64'h0, 0, 0, 0, 0, 6, 'hFF, 'hFF);
      add_row(0, 1, 'h03, 0, 64'h0, 0, 0, 0, 0, 7, 'hFF, 'hFF);
      add_row(1, 1, 'h0F, 0, 64'hFFFF_FFFF_FFFF_FFF0, 38, 1, 'h22, 'h0301, 8, 'hFF, 'hFF);
      add_row(1, 1, 'h3F, 1, 64'h0000_0001_0000_0F00, 32, 2, 'h00, 'h0302, 9, 'hFF, 'hFF);
      add_row(1, 1, 'h0F, 5, 64'h0000_0000_0000_1234, 20, 1, 'h23, 'h0303, 10, 'hFF, 'hFF);
      // aperture codes just outside and at the low edge of the range
      add_row(1, 1, 'h0F, 0, 64'hFFFF_0000_FFFF_0000, 6, 4, 'h31, 'h0400, 11, 'hFF, 'hFF);
      add_row(1, 0, 'hFF, 1, 64'h0123_4567_89AB_CDEF, 39, 8, 'h00, 'h0401, 12, 'hFF, 'hFF);
      add_row(0, 1, 'h1F, 0, 64'h0, 0, 0, 0, 0, 13, 'hFF, 'hFF);
      add_row(1, 1, 'h0F, 0, 64'h0123_4567_89AB_CDEF, 7, 4, 'h32, 'h0402, 14, 'hFF, 'hFF);
      // back-pressure on both outputs with reads and writes interleaved
      add_row(1, 0, 'hFF, 1, 64'h0000_0000_00AB_C000, 24, 16, 'h00, 'h0500, 15, 'h93, 'h4D);
      add_row(0, 1, 'h3F, 0, 64'h0, 0, 0, 0, 0, 16, 'h93, 'h4D);
      add_row(1, 1, 'h0F, 0, 64'h0000_0000_00AB_C100, 24, 1, 'h41, 'h0501, 17, 'h93, 'h4D);
      add_row(1, 1, 'h1F, 1, 64'h0000_0000_0000_7FFC, 16, 1, 'h00, 'h0502, 18, 'h21, 'h4D);
      add_row(1, 1, 'h0F, 0, 64'h0000_0010_0000_0040, 36, 2, 'h42, 'h0503, 19, 'h21, 'h4D);
      add_row(1, 0, 'hFF, 1, 64'h0000_000F_0000_2000, 36, 12, 'h00, 'h0504, 20, 'h21, 'h01);
      add_row(0, 1, 'h7F, 0, 64'h0, 0, 0, 0, 0, 21, 'h01, 'h01);
      // unsupported request while the write output is stalled
      add_row(1, 0, 'hFF, 3, 64'h0000_0000_0000_5000, 20, 8, 'h44, 'h0506, 23, 'h01, 'h01);
      add_row(0, 0, 'hFF, 0, 64'h0, 0, 0, 0, 0, 24, 'h01, 'h01);
      add_row(0, 1, 'h0F, 0, 64'h0, 0, 0, 0, 0, 25, 'h01, 'h01);
      add_row(1, 1, 'h0F, 0, 64'h0000_0000_0000_3FF8, 14, 3, 'h43, 'h0505, 22, 'h01, 'h01);
      repeat (4) @(posedge clk);
      #1;
      rstn = 1'b1;
      foreach (rows[i]) begin
         if (!timed_out)
            send_beat(rows[i]);
      end
      cq_valid_i = 1'b0;
      if (!timed_out)
         drain_outputs();
      repeat (3) @(negedge clk);
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
      if (mismatch_count == 0 && other_count == 0 && !timed_out)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
cq_pkg.sv
cq_request_router.sv
cq_read_capture.sv
cq_write_stage.sv
cq_completer_top.sv
cq_completer_properties.sv
tb_cq_completer.sv

// ==== Makefile ====
# Verilator build and run of the completer request front end testbench

SRCS := $(wildcard *.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_cq_completer: src.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_cq_completer -f src.f

run: obj_dir/Vtb_cq_completer
	-./obj_dir/Vtb_cq_completer > sim.log 2>&1
	cat sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
